// File: scope_capture.f
+incdir+hw
hw/capture_pkg.sv
hw/control_pkg.sv
hw/lane_capture.sv
hw/config_regs.sv
hw/acq_controller.sv
hw/sample_ram.sv
hw/scope_top.sv
tests/scope_assertions.sv
tests/scope_checker.sv
tests/tb_scope.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_scope
FLIST     ?= scope_capture.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/scope_patterns.txt
# name chan lower upper pre post decim ramp_start ramp_step
# thresholds and ramp values are signed decimal, decim is the exponent
rising_ramp 0 -100 200 8 16 0 -300 4
no_trigger 1 -400 100 4 8 0 0 1
decim_by_4 2 -20 60 4 6 2 -80 3
early_crossing 3 -10 20 10 5 0 -30 10
chan_two 2 -200 -100 6 10 1 -300 5
chan_one 1 0 300 3 20 0 -64 7

// File: tests/tb_scope.sv
`include "scope_defines.svh"

module tb_scope;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 400;

   logic                      clk;
   logic                      rst_n;
   logic [`SCOPE_LANE_W-1:0]  lane_val [`SCOPE_NUM_CH];
   logic                      cfg_wr;
   control_pkg::cfg_addr_e    cfg_addr;
   control_pkg::cfg_word_u    cfg_data;
   logic                      arm;
   logic [`SCOPE_RAM_AW-1:0]  rd_addr;
   logic                      reading;
   control_pkg::acq_state_e   acq_state;
   logic [`SCOPE_RAM_AW-1:0]  trig_addr;
   capture_pkg::frame_t       rd_data;

   logic [31:0] lcg_state = 32'd83;
   logic [9:0]  ramp_val = '0;
   logic [9:0]  ramp_step = '0;
   int          ramp_chan = 0;
   int          setup_errs = 0;

   scope_top u_scope_top (
      .lvds_clk_slow_clkin1 (clk),
      .i_rst_n              (rst_n),
      .i_lane_0_data        (lane_val[0]),
      .i_lane_1_data        (lane_val[1]),
      .i_lane_2_data        (lane_val[2]),
      .i_lane_3_data        (lane_val[3]),
      .i_cfg_wr             (cfg_wr),
      .i_cfg_addr           (cfg_addr),
      .i_cfg_data           (cfg_data),
      .i_arm                (arm),
      .i_rd_addr            (rd_addr),
      .o_acq_state          (acq_state),
      .o_trig_addr          (trig_addr),
      .o_rd_data            (rd_data)
   );

   scope_checker u_checker (
      .lvds_clk_slow_clkin1 (clk),
      .i_rst_n              (rst_n),
      .i_lane_0_data        (lane_val[0]),
      .i_lane_1_data        (lane_val[1]),
      .i_lane_2_data        (lane_val[2]),
      .i_lane_3_data        (lane_val[3]),
      .i_cfg_wr             (cfg_wr),
      .i_cfg_addr           (cfg_addr),
      .i_cfg_data           (cfg_data),
      .i_arm                (arm),
      .i_rd_addr            (rd_addr),
      .i_reading            (reading),
      .i_acq_state          (acq_state),
      .i_trig_addr          (trig_addr),
      .i_rd_data            (rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Wait for an edge and move every lane on by one sample
   task automatic tick();
      @(posedge clk);
      #2;
      for (int ch = 0; ch < `SCOPE_NUM_CH; ch++) begin
         if (ch == ramp_chan) begin
            lane_val[ch] = ramp_val;
            ramp_val = ramp_val + ramp_step;
         end else begin
            lcg_state = lcg_next(lcg_state);
            lane_val[ch] = lcg_state[25:16];
         end
      end
   endtask

   task automatic run_test(input string name, input int chan, input int lower, input int upper,
                           input int pre, input int post, input int decim,
                           input int start, input int step);
      control_pkg::cfg_word_u w;
      bit timed_out;
      u_checker.begin_test(name);
      ramp_chan = chan;
      ramp_val = 10'(start);
      ramp_step = 10'(step);
      tick();
      w = '0;
      w.thr.lower = 12'(lower);
      w.thr.upper = 12'(upper);
      w.thr.trig_chan = 2'(chan);
      cfg_wr = 1'b1;
      cfg_addr = control_pkg::CFG_ADDR_THRESH;
      cfg_data = w;
      tick();
      w = '0;
      w.len.pre_count = 8'(pre);
      w.len.post_count = 8'(post);
      w.len.decim = 3'(decim);
      cfg_addr = control_pkg::CFG_ADDR_LENGTH;
      cfg_data = w;
      tick();
      cfg_wr = 1'b0;
      arm = 1'b1;
      tick();
      arm = 1'b0;
      timed_out = 1'b1;
      for (int c = 0; c < WAIT_LIMIT; c++) begin
         tick();
         if (acq_state == control_pkg::ACQ_DONE) begin
            timed_out = 1'b0;
            break;
         end
      end
      // Only a finished capture is read back since a running one keeps writing
      if (!timed_out) begin
         reading = 1'b1;
         for (int a = 0; a < 256; a++) begin
            rd_addr = 8'(a);
            tick();
         end
         reading = 1'b0;
         tick();
         tick();
      end
      u_checker.end_test(timed_out);
   endtask

   initial begin
      int    fd;
      int    n;
      int    chan, lower, upper, pre, post, decim, start, step;
      string line;
      string name;
      int    fail_total;
      int    assert_fails;
      rst_n = 1'b0;
      cfg_wr = 1'b0;
      cfg_addr = control_pkg::CFG_ADDR_THRESH;
      cfg_data = '0;
      arm = 1'b0;
      rd_addr = '0;
      reading = 1'b0;
      for (int ch = 0; ch < `SCOPE_NUM_CH; ch++) lane_val[ch] = '0;
      repeat (16) tick();
      rst_n = 1'b1;
      tick();
      u_checker.check_reset();
      fd = $fopen("tests/scope_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open the pattern file tests/scope_patterns.txt");
         setup_errs++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %d %d %d %d %d %d %d %d",
                           name, chan, lower, upper, pre, post, decim, start, step);
               if (n == 9) run_test(name, chan, lower, upper, pre, post, decim, start, step);
            end
         end
         $fclose(fd);
      end
      fail_total = u_checker.fail_count + setup_errs;
      assert_fails = u_scope_top.u_scope_assertions.fail_cnt;
      $display("%0d tests passed, %0d tests failed, %0d assertion failures",
               u_checker.pass_count, fail_total, assert_fails);
      if (fail_total == 0 && assert_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: tests/scope_checker.sv
`include "scope_defines.svh"

module scope_checker (
   input logic                      lvds_clk_slow_clkin1,
   input logic                      i_rst_n,
   input logic [`SCOPE_LANE_W-1:0]  i_lane_0_data,
   input logic [`SCOPE_LANE_W-1:0]  i_lane_1_data,
   input logic [`SCOPE_LANE_W-1:0]  i_lane_2_data,
   input logic [`SCOPE_LANE_W-1:0]  i_lane_3_data,
   input logic                      i_cfg_wr,
   input control_pkg::cfg_addr_e    i_cfg_addr,
   input control_pkg::cfg_word_u    i_cfg_data,
   input logic                      i_arm,
   input logic [`SCOPE_RAM_AW-1:0]  i_rd_addr,
   input logic                      i_reading,
   input control_pkg::acq_state_e   i_acq_state,
   input logic [`SCOPE_RAM_AW-1:0]  i_trig_addr,
   input capture_pkg::frame_t       i_rd_data
);

   timeunit 1ns;
   timeprecision 100ps;

   int pass_count = 0;
   int fail_count = 0;
   int test_errs = 0;
   string test_name = "none";

   // Model of the settings and of one acquisition
   capture_pkg::sample_t    m_lower;
   capture_pkg::sample_t    m_upper;
   int                      m_chan;
   int                      m_pre;
   int                      m_post;
   int                      m_decim;
   control_pkg::acq_state_e m_state;
   logic [7:0]              m_waddr;
   logic [7:0]              m_trig_addr;
   int                      m_cnt;
   int                      m_edge;
   bit                      m_hyst;
   bit                      m_trig;
   capture_pkg::frame_t     exp_mem [256];
   bit                      exp_valid [256];
   bit                      rd_pending;
   logic [7:0]              rd_prev;

   task automatic store_frame();
      capture_pkg::frame_t  f;
      capture_pkg::sample_t s;
      f[0] = capture_pkg::sample_t'($signed(i_lane_0_data));
      f[1] = capture_pkg::sample_t'($signed(i_lane_1_data));
      f[2] = capture_pkg::sample_t'($signed(i_lane_2_data));
      f[3] = capture_pkg::sample_t'($signed(i_lane_3_data));
      s = f[m_chan];
      exp_mem[m_waddr] = f;
      exp_valid[m_waddr] = 1'b1;
      if (m_state == control_pkg::ACQ_FILLING) begin
         m_cnt++;
         if (m_cnt >= m_pre) begin
            m_state = control_pkg::ACQ_ARMED;
            m_cnt = 0;
         end
      end else if (m_trig) begin
         m_cnt++;
         if (m_cnt >= m_post) m_state = control_pkg::ACQ_DONE;
      end else if (m_hyst && s >= m_upper) begin
         m_trig = 1'b1;
         m_trig_addr = m_waddr;
         m_cnt = 0;
         if (m_post == 0) m_state = control_pkg::ACQ_DONE;
      end else if (s <= m_lower) begin
         m_hyst = 1'b1;
      end
      m_waddr = m_waddr + 8'd1;
   endtask

   always @(posedge lvds_clk_slow_clkin1) begin
      if (!i_rst_n) begin
         m_lower = '0;
         m_upper = '0;
         m_chan = 0;
         m_pre = 0;
         m_post = 0;
         m_decim = 0;
         m_state = control_pkg::ACQ_IDLE;
         m_trig_addr = '0;
         rd_pending = 1'b0;
      end else begin
         // Read data belongs to the address of the previous cycle
         if (rd_pending && exp_valid[rd_prev] && i_rd_data !== exp_mem[rd_prev]) begin
            $display("Mismatch %s: address %0d expected %h actual %h",
                     test_name, rd_prev, exp_mem[rd_prev], i_rd_data);
            test_errs++;
         end
         rd_pending = i_reading;
         rd_prev = i_rd_addr;
         if (i_cfg_wr && i_cfg_addr == control_pkg::CFG_ADDR_THRESH) begin
            m_lower = $signed(i_cfg_data.thr.lower);
            m_upper = $signed(i_cfg_data.thr.upper);
            m_chan = int'(i_cfg_data.thr.trig_chan);
         end else if (i_cfg_wr) begin
            m_pre = int'(i_cfg_data.len.pre_count);
            m_post = int'(i_cfg_data.len.post_count);
            m_decim = int'(i_cfg_data.len.decim);
         end
         if (i_arm) begin
            foreach (exp_valid[a]) exp_valid[a] = 1'b0;
            m_state = control_pkg::ACQ_FILLING;
            m_waddr = '0;
            m_cnt = 0;
            m_hyst = 1'b0;
            m_trig = 1'b0;
            m_edge = 0;
            store_frame();
         end else if (m_state == control_pkg::ACQ_FILLING ||
                      m_state == control_pkg::ACQ_ARMED) begin
            m_edge++;
            if ((m_edge % (1 << m_decim)) == 0) store_frame();
         end
      end
   end

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      if (test_errs == 0) begin
         $display("test %s passed", test_name);
         pass_count++;
      end else begin
         $display("test %s failed with %0d errors", test_name, test_errs);
         fail_count++;
      end
   endtask

   task automatic check_reset();
      begin_test("reset");
      if (i_acq_state !== control_pkg::ACQ_IDLE) begin
         $display("Mismatch reset: state expected %0d actual %0d",
                  control_pkg::ACQ_IDLE, i_acq_state);
         test_errs++;
      end
      if (i_trig_addr !== 8'd0) begin
         $display("Mismatch reset: trigger address expected 0 actual %0d", i_trig_addr);
         test_errs++;
      end
      finish_test();
   endtask

   task automatic end_test(input bit timed_out);
      if (timed_out && m_state == control_pkg::ACQ_DONE) begin
         $display("test %s timed out waiting for the capture to finish", test_name);
         test_errs++;
      end else if (!timed_out && m_state != control_pkg::ACQ_DONE) begin
         $display("test %s finished although no trigger was predicted", test_name);
         test_errs++;
      end else if (!timed_out && i_trig_addr !== m_trig_addr) begin
         $display("Mismatch %s: trigger address expected %0d actual %0d",
                  test_name, m_trig_addr, i_trig_addr);
         test_errs++;
      end
      if (i_acq_state !== m_state) begin
         $display("Mismatch %s: state expected %0d actual %0d", test_name, m_state, i_acq_state);
         test_errs++;
      end
      finish_test();
   endtask

endmodule

// File: tests/scope_assertions.sv
module scope_assertions (
   input logic                    lvds_clk_slow_clkin1,
   input logic                    i_rst_n,
   input logic                    i_arm,
   input control_pkg::acq_state_e o_acq_state,
   input logic [7:0]              o_trig_addr
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;

   // Trigger position is frozen once the capture is complete
   trig_addr_held: assert property (@(posedge lvds_clk_slow_clkin1) disable iff (!i_rst_n)
      (o_acq_state == control_pkg::ACQ_DONE && !i_arm) |=> $stable(o_trig_addr))
      else begin
         $error("trigger address changed while done");
         fail_cnt++;
      end

   // Only an arm strobe leaves done
   done_until_arm: assert property (@(posedge lvds_clk_slow_clkin1) disable iff (!i_rst_n)
      (o_acq_state == control_pkg::ACQ_DONE && !i_arm) |=> o_acq_state == control_pkg::ACQ_DONE)
      else begin
         $error("state left done without arm");
         fail_cnt++;
      end

   idle_after_reset: assert property (@(posedge lvds_clk_slow_clkin1)
      !i_rst_n |=> o_acq_state == control_pkg::ACQ_IDLE)
      else begin
         $error("state not idle after reset");
         fail_cnt++;
      end

endmodule

bind scope_top scope_assertions u_scope_assertions (
   .lvds_clk_slow_clkin1 (lvds_clk_slow_clkin1),
   .i_rst_n              (i_rst_n),
   .i_arm                (i_arm),
   .o_acq_state          (o_acq_state),
   .o_trig_addr          (o_trig_addr)
);

// File: hw/scope_top.sv
`include "scope_defines.svh"

module scope_top (
   input  logic                      lvds_clk_slow_clkin1,
   input  logic                      i_rst_n,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_0_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_1_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_2_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_3_data,
   input  logic                      i_cfg_wr,
   input  control_pkg::cfg_addr_e    i_cfg_addr,
   input  control_pkg::cfg_word_u    i_cfg_data,
   input  logic                      i_arm,
   input  logic [`SCOPE_RAM_AW-1:0]  i_rd_addr,
   output control_pkg::acq_state_e   o_acq_state,
   output logic [`SCOPE_RAM_AW-1:0]  o_trig_addr,
   output capture_pkg::frame_t       o_rd_data
);

   capture_pkg::frame_t      frame;
   logic                     frame_stb;
   capture_pkg::sample_t     lower_thresh;
   capture_pkg::sample_t     upper_thresh;
   logic [1:0]               trig_chan;
   logic [7:0]               pre_count;
   logic [7:0]               post_count;
   logic [2:0]               decim;
   logic                     ram_wr;
   logic [`SCOPE_RAM_AW-1:0] ram_waddr;

   lane_capture u_lane_capture (
      .lvds_clk_slow_clkin1 (lvds_clk_slow_clkin1),
      .i_rst_n              (i_rst_n),
      .i_lane_0_data        (i_lane_0_data),
      .i_lane_1_data        (i_lane_1_data),
      .i_lane_2_data        (i_lane_2_data),
      .i_lane_3_data        (i_lane_3_data),
      .i_decim              (decim),
      .i_restart            (i_arm),
      .o_frame              (frame),
      .o_frame_stb          (frame_stb)
   );

   config_regs u_config_regs (
      .lvds_clk_slow_clkin1 (lvds_clk_slow_clkin1),
      .i_rst_n              (i_rst_n),
      .i_cfg_wr             (i_cfg_wr),
      .i_cfg_addr           (i_cfg_addr),
      .i_cfg_data           (i_cfg_data),
      .o_lower_thresh       (lower_thresh),
      .o_upper_thresh       (upper_thresh),
      .o_trig_chan          (trig_chan),
      .o_pre_count          (pre_count),
      .o_post_count         (post_count),
      .o_decim              (decim)
   );

   acq_controller u_acq_controller (
      .lvds_clk_slow_clkin1 (lvds_clk_slow_clkin1),
      .i_rst_n              (i_rst_n),
      .i_arm                (i_arm),
      .i_frame              (frame),
      .i_frame_stb          (frame_stb),
      .i_lower_thresh       (lower_thresh),
      .i_upper_thresh       (upper_thresh),
      .i_trig_chan          (trig_chan),
      .i_pre_count          (pre_count),
      .i_post_count         (post_count),
      .o_ram_wr             (ram_wr),
      .o_ram_waddr          (ram_waddr),
      .o_acq_state          (o_acq_state),
      .o_trig_addr          (o_trig_addr)
   );

   sample_ram u_sample_ram (
      .lvds_clk_slow_clkin1 (lvds_clk_slow_clkin1),
      .i_wr                 (ram_wr),
      .i_waddr              (ram_waddr),
      .i_wdata              (frame),
      .i_raddr              (i_rd_addr),
      .o_rdata              (o_rd_data)
   );

endmodule

// File: hw/sample_ram.sv
`include "scope_defines.svh"

module sample_ram (
   input  logic                      lvds_clk_slow_clkin1,
   input  logic                      i_wr,
   input  logic [`SCOPE_RAM_AW-1:0]  i_waddr,
   input  capture_pkg::frame_t       i_wdata,
   input  logic [`SCOPE_RAM_AW-1:0]  i_raddr,
   output capture_pkg::frame_t       o_rdata
);

   capture_pkg::frame_t mem [2**`SCOPE_RAM_AW];

   // Read data appears one cycle after the address
   always_ff @(posedge lvds_clk_slow_clkin1) begin
      if (i_wr) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

endmodule

// File: hw/acq_controller.sv
`include "scope_defines.svh"

module acq_controller (
   input  logic                      lvds_clk_slow_clkin1,
   input  logic                      i_rst_n,
   input  logic                      i_arm,
   input  capture_pkg::frame_t       i_frame,
   input  logic                      i_frame_stb,
   input  capture_pkg::sample_t      i_lower_thresh,
   input  capture_pkg::sample_t      i_upper_thresh,
   input  logic [1:0]                i_trig_chan,
   input  logic [7:0]                i_pre_count,
   input  logic [7:0]                i_post_count,
   output logic                      o_ram_wr,
   output logic [`SCOPE_RAM_AW-1:0]  o_ram_waddr,
   output control_pkg::acq_state_e   o_acq_state,
   output logic [`SCOPE_RAM_AW-1:0]  o_trig_addr
);

   control_pkg::acq_state_e  state_q;
   logic [`SCOPE_RAM_AW-1:0] waddr_q;
   logic [`SCOPE_RAM_AW-1:0] trig_addr_q;
   logic [7:0]               frame_cnt;
   logic [8:0]               cnt_next;
   logic                     hyst_q;
   logic                     triggered_q;
   logic                     ram_wr;
   capture_pkg::sample_t     trig_sample;

   assign trig_sample = i_frame[i_trig_chan];
   assign cnt_next    = {1'b0, frame_cnt} + 9'd1;

   // Every strobed frame is stored while filling or armed
   assign ram_wr = i_frame_stb &&
                   (state_q == control_pkg::ACQ_FILLING ||
                    state_q == control_pkg::ACQ_ARMED);

   always_ff @(posedge lvds_clk_slow_clkin1) begin
      if (!i_rst_n) begin
         state_q     <= control_pkg::ACQ_IDLE;
         waddr_q     <= '0;
         trig_addr_q <= '0;
         frame_cnt   <= '0;
         hyst_q      <= 1'b0;
         triggered_q <= 1'b0;
      end else if (i_arm) begin
         // Arm restarts from any state
         state_q     <= control_pkg::ACQ_FILLING;
         waddr_q     <= '0;
         frame_cnt   <= '0;
         hyst_q      <= 1'b0;
         triggered_q <= 1'b0;
      end else if (ram_wr) begin
         // Circular buffer, wraps at the RAM depth
         waddr_q <= waddr_q + 1'b1;
         case (state_q)
            control_pkg::ACQ_FILLING: begin
               frame_cnt <= frame_cnt + 8'd1;
               if (cnt_next >= {1'b0, i_pre_count}) begin
                  state_q   <= control_pkg::ACQ_ARMED;
                  frame_cnt <= '0;
               end
            end
            default: begin
               if (triggered_q) begin
                  // Post-trigger frames
                  frame_cnt <= frame_cnt + 8'd1;
                  if (cnt_next >= {1'b0, i_post_count}) begin
                     state_q <= control_pkg::ACQ_DONE;
                  end
               end else if (hyst_q && trig_sample >= i_upper_thresh) begin
                  triggered_q <= 1'b1;
                  trig_addr_q <= waddr_q;
                  frame_cnt   <= '0;
                  if (i_post_count == 8'd0) begin
                     state_q <= control_pkg::ACQ_DONE;
                  end
               end else if (trig_sample <= i_lower_thresh) begin
                  // Signal went low enough, next upper crossing counts
                  hyst_q <= 1'b1;
               end
            end
         endcase
      end
   end

   assign o_ram_wr    = ram_wr;
   assign o_ram_waddr = waddr_q;
   assign o_acq_state = state_q;
   assign o_trig_addr = trig_addr_q;

endmodule

// File: hw/config_regs.sv
module config_regs (
   input  logic                    lvds_clk_slow_clkin1,
   input  logic                    i_rst_n,
   input  logic                    i_cfg_wr,
   input  control_pkg::cfg_addr_e  i_cfg_addr,
   input  control_pkg::cfg_word_u  i_cfg_data,
   output capture_pkg::sample_t    o_lower_thresh,
   output capture_pkg::sample_t    o_upper_thresh,
   output logic [1:0]              o_trig_chan,
   output logic [7:0]              o_pre_count,
   output logic [7:0]              o_post_count,
   output logic [2:0]              o_decim
);

   // The address picks which view of the data word is decoded
   always_ff @(posedge lvds_clk_slow_clkin1) begin
      if (!i_rst_n) begin
         o_lower_thresh <= '0;
         o_upper_thresh <= '0;
         o_trig_chan    <= '0;
         o_pre_count    <= '0;
         o_post_count   <= '0;
         o_decim        <= '0;
      end else if (i_cfg_wr) begin
         case (i_cfg_addr)
            control_pkg::CFG_ADDR_THRESH: begin
               o_lower_thresh <= capture_pkg::sample_t'(i_cfg_data.thr.lower);
               o_upper_thresh <= capture_pkg::sample_t'(i_cfg_data.thr.upper);
               o_trig_chan    <= i_cfg_data.thr.trig_chan;
            end
            default: begin
               o_pre_count  <= i_cfg_data.len.pre_count;
               o_post_count <= i_cfg_data.len.post_count;
               o_decim      <= i_cfg_data.len.decim;
            end
         endcase
      end
   end

endmodule

// File: hw/lane_capture.sv
`include "scope_defines.svh"

module lane_capture (
   input  logic                      lvds_clk_slow_clkin1,
   input  logic                      i_rst_n,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_0_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_1_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_2_data,
   input  logic [`SCOPE_LANE_W-1:0]  i_lane_3_data,
   input  logic [2:0]                i_decim,
   input  logic                      i_restart,
   output capture_pkg::frame_t       o_frame,
   output logic                      o_frame_stb
);

   localparam int EXT_W = `SCOPE_SAMPLE_W - `SCOPE_LANE_W;

   logic [`SCOPE_LANE_W-1:0] lane_data [`SCOPE_NUM_CH];
   capture_pkg::frame_t      frame_q;
   // Wide enough for the largest ratio of 2**7
   logic [6:0]               decim_cnt;
   logic [6:0]               decim_mask;
   logic                     stb_q;

   assign lane_data[0] = i_lane_0_data;
   assign lane_data[1] = i_lane_1_data;
   assign lane_data[2] = i_lane_2_data;
   assign lane_data[3] = i_lane_3_data;

   // Exponent 7 wraps to zero and gives the all-ones mask
   assign decim_mask = (7'd1 << i_decim) - 7'd1;

   always_ff @(posedge lvds_clk_slow_clkin1) begin
      for (int ch = 0; ch < `SCOPE_NUM_CH; ch++) begin
         frame_q[ch] <= {{EXT_W{lane_data[ch][`SCOPE_LANE_W-1]}}, lane_data[ch]};
      end
   end

   // Strobe lines up with the registered frame, first one right after arm
   always_ff @(posedge lvds_clk_slow_clkin1) begin
      if (!i_rst_n) begin
         decim_cnt <= '0;
         stb_q     <= 1'b0;
      end else if (i_restart) begin
         decim_cnt <= 7'd1;
         stb_q     <= 1'b1;
      end else begin
         decim_cnt <= decim_cnt + 7'd1;
         stb_q     <= (decim_cnt & decim_mask) == 7'd0;
      end
   end

   assign o_frame     = frame_q;
   assign o_frame_stb = stb_q;

endmodule

// File: hw/control_pkg.sv
`include "scope_defines.svh"

package control_pkg;

   // Threshold word, address 0
   typedef struct packed {
      logic [`SCOPE_CFG_W-2*`SCOPE_SAMPLE_W-3:0] rsvd;
      logic [1:0]                               trig_chan;
      logic [`SCOPE_SAMPLE_W-1:0]               upper;
      logic [`SCOPE_SAMPLE_W-1:0]               lower;
   } thresh_view_t;

   // Length word, address 1
   typedef struct packed {
      logic [`SCOPE_CFG_W-20:0] rsvd;
      logic [2:0]               decim;
      logic [7:0]               post_count;
      logic [7:0]               pre_count;
   } length_view_t;

   typedef union packed {
      thresh_view_t thr;
      length_view_t len;
   } cfg_word_u;

   typedef enum logic {
      CFG_ADDR_THRESH = 1'b0,
      CFG_ADDR_LENGTH = 1'b1
   } cfg_addr_e;

   typedef enum logic [1:0] {
      ACQ_IDLE    = 2'd0,
      ACQ_FILLING = 2'd1,
      ACQ_ARMED   = 2'd2,
      ACQ_DONE    = 2'd3
   } acq_state_e;

endpackage

// File: hw/capture_pkg.sv
`include "scope_defines.svh"

package capture_pkg;

   // One sign-extended ADC sample
   typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;

   // One RAM word, channel 0 in the lowest bits
   typedef sample_t [`SCOPE_NUM_CH-1:0] frame_t;

endpackage

// File: hw/scope_defines.svh
`ifndef SCOPE_DEFINES_SVH
`define SCOPE_DEFINES_SVH

// Number of LVDS lanes, one channel per lane
`define SCOPE_NUM_CH   4

// Deserialized lane word and sign-extended sample
`define SCOPE_LANE_W   10
`define SCOPE_SAMPLE_W 12

// Frame memory of 256 entries
`define SCOPE_RAM_AW   8
`define SCOPE_CFG_W    32

`endif
